// ==== source/cpu_pkg.sv ====
// cpu_pkg
// Shared types for the tlcs_lite execution core: data widths, register
// byte codes, the phase and ALU enums, the ALU control bundle and the
// data-memory command, plus the register-code helpers used by decode.
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] long_t;      // data, opcode windows, addresses
    typedef logic [7:0]  reg_code_t;  // {bank nibble, reg[1:0], lane[1:0]}
    typedef logic [1:0]  zz_t;        // 0 byte, 1 word, 2 long
    typedef logic [2:0]  we_t;        // one-hot byte/word/long
    typedef logic [1:0]  fetch_cnt_t; // bytes consumed this cycle

    typedef enum logic [4:0] {
        FETCH    = 5'd0,
        IDX      = 5'd1,
        LD_RAM   = 5'd2,
        EXEC     = 5'd3,
        FILL_IMM = 5'd4,
        ST_RAM   = 5'd5,
        ILLEGAL  = 5'd31
    } phase_e;

    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        logic      smux;  // 1 picks imm, 0 the source register
        long_t     imm;
        reg_code_t src;
        reg_code_t dst;
        we_t       we;
    } alu_ctrl_t;

    typedef struct packed {
        long_t addr;
        long_t data;
        zz_t   zz;
        logic  wr;
    } mem_cmd_t;

    function automatic we_t expand_zz(input zz_t zz);
        return (zz == 2'd0) ? 3'b001 : (zz == 2'd1) ? 3'b010 : 3'b100;
    endfunction

    // short register codes: bytes W,A,B,C,D,E,H,L or longs XWA..XHL
    function automatic reg_code_t expand_reg(input logic [2:0] short_reg, input zz_t zz);
        if (zz == 2'd0) begin
            return {4'he, short_reg[2:1], 1'b0, ~short_reg[0]};
        end else if (short_reg[2]) begin
            return {4'hf, short_reg[1:0], 2'b00};
        end
        return {4'he, short_reg[1:0], 2'b00};
    endfunction

endpackage

// ==== source/op_fetch.sv ====
// op_fetch
// Instruction byte buffer. Prefetches bytes over a four-phase memory port
// into a circular buffer and presents the oldest four as a little-endian
// opcode window. The decoder and index unit drop bytes from the head.
`timescale 1ns/1ps

module op_fetch import cpu_pkg::*; #(
    parameter int BUF_BYTES = 8
) (
    input  logic       clk,
    input  logic       rst,
    output logic       imem_req,
    output long_t      imem_addr,
    input  logic       imem_ack,
    input  byte_t      imem_data,
    input  fetch_cnt_t fetched,
    input  fetch_cnt_t idx_fetched,
    output long_t      op,
    output logic       op_ok
);

    localparam int PW = $clog2(BUF_BYTES);
    localparam int CW = $clog2(BUF_BYTES + 1);

    byte_t         buf_q [BUF_BYTES];
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [CW-1:0] count_q;
    long_t         pc_q;
    logic [2:0]    consumed;
    logic          capture;

    // pointer wrap for depths that are not a power of two
    function automatic logic [PW-1:0] wrap(input logic [PW:0] idx);
        return (idx >= BUF_BYTES) ? PW'(idx - BUF_BYTES) : idx[PW-1:0];
    endfunction

    assign consumed  = {1'b0, fetched} + {1'b0, idx_fetched};
    assign capture   = imem_req && imem_ack;
    assign imem_addr = pc_q;
    assign op_ok     = count_q >= CW'(4);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op[8*i +: 8] = buf_q[wrap({1'b0, head_q} + (PW+1)'(i))];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            pc_q     <= '0;
            imem_req <= 1'b0;
        end else begin
            head_q  <= wrap({1'b0, head_q} + (PW+1)'(consumed));
            count_q <= count_q + CW'(capture) - CW'(consumed);
            if (capture) begin
                tail_q   <= wrap({1'b0, tail_q} + (PW+1)'(1));
                pc_q     <= pc_q + 32'd1;
                imem_req <= 1'b0;          // memory drops ack next
            end else if (!imem_req && !imem_ack && count_q < CW'(BUF_BYTES)) begin
                imem_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) buf_q[tail_q] <= imem_data;
    end

    // decoder plus index unit may only drop bytes that are present
    assert property (@(posedge clk) disable iff (rst) consumed <= count_q);

endmodule

// ==== source/ctrl.sv ====
// ctrl
// Instruction decode and sequencing FSM. Walks each instruction through
// FETCH, EXEC, FILL_IMM and the IDX -> LD_RAM / ST_RAM path, drives the
// ALU control bundle and tells the fetch buffer how many bytes to drop.
// Undefined opcodes park the machine in ILLEGAL.
`timescale 1ns/1ps

module ctrl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  long_t      op,
    input  logic       op_ok,
    output fetch_cnt_t fetched,
    output logic       idx_en,
    input  logic       idx_ok,
    output logic       ldram_en,
    output logic       stram_en,
    input  logic       mem_done,
    input  long_t      load_data,
    output alu_ctrl_t  alu,
    output logic       illegal
);

    phase_e    phase_q, nx_phase;
    alu_ctrl_t nx_alu;
    zz_t       op_zz_q, nx_op_zz;
    zz_t       imm_zz;
    logic      imm_ok;
    logic      nx_idx_en, nx_ldram_en, nx_stram_en;
    logic      ram_wait;

    // LD R,# size field: 2 byte, 3 word, 4 long
    assign imm_ok = (op[6:4] >= 3'd2) && (op[6:4] <= 3'd4);
    assign imm_zz = (op[6:4] == 3'd2) ? 2'd0 : (op[6:4] == 3'd3) ? 2'd1 : 2'd2;

    always_comb begin
        fetched     = '0;
        nx_phase    = phase_q;
        nx_alu      = alu;
        nx_alu.we   = '0;              // one write per instruction
        nx_op_zz    = op_zz_q;
        nx_idx_en   = idx_en;
        nx_ldram_en = ldram_en;
        nx_stram_en = stram_en;
        if (op_ok && !ram_wait) begin
            case (phase_q)
                FETCH: begin
                    nx_alu.op   = ALU_NOP;
                    nx_alu.smux = 1'b0;
                    casez (op[7:0])
                        8'h00: fetched = 2'd1; // NOP
                        8'b11??_00??: begin    // indexed prefix
                            if (op[5:4] == 2'd3) begin
                                nx_phase = ILLEGAL;
                            end else begin
                                nx_op_zz   = op[5:4];
                                nx_alu.src = {4'he, op[1:0], 2'b00}; // base reg
                                nx_idx_en  = 1'b1;
                                nx_phase   = IDX;  // idx_unit drops the bytes
                            end
                        end
                        8'b11??_1???: begin    // two-register prefix, r part
                            if (op[5:4] == 2'd3) begin
                                nx_phase = ILLEGAL;
                            end else begin
                                nx_op_zz   = op[5:4];
                                nx_alu.dst = expand_reg(op[2:0], op[5:4]);
                                nx_phase   = EXEC;
                                fetched    = 2'd1;
                            end
                        end
                        8'b0???_0???: begin    // LD R,#
                            if (!imm_ok) begin
                                nx_phase = ILLEGAL;
                            end else begin
                                nx_op_zz    = imm_zz;
                                nx_alu.op   = ALU_MOVE;
                                nx_alu.smux = 1'b1;
                                nx_alu.dst  = expand_reg(op[2:0], imm_zz);
                                nx_alu.imm  = {24'd0, op[15:8]};
                                fetched     = 2'd2;
                                if (imm_zz == 2'd0) begin
                                    nx_alu.we = expand_zz(imm_zz);
                                end else begin
                                    nx_phase = FILL_IMM; // write once complete
                                end
                            end
                        end
                        default: nx_phase = ILLEGAL;
                    endcase
                end
                IDX: if (idx_ok) begin
                    nx_idx_en = 1'b0;
                    casez (op[7:0])
                        8'b0010_0???: begin    // LD R,(mem)
                            nx_alu.dst  = expand_reg(op[2:0], op_zz_q);
                            nx_ldram_en = 1'b1;
                            nx_phase    = LD_RAM;
                        end
                        8'b01??_0???: begin    // LD (mem),R
                            if (op[5:4] == 2'd3) begin
                                nx_phase = ILLEGAL;
                            end else begin
                                nx_op_zz    = op[5:4];
                                nx_alu.src  = expand_reg(op[2:0], op[5:4]);
                                nx_stram_en = 1'b1;
                                nx_phase    = ST_RAM;
                            end
                        end
                        default: nx_phase = ILLEGAL;
                    endcase
                end
                LD_RAM: if (mem_done) begin
                    nx_ldram_en = 1'b0;
                    nx_alu.op   = ALU_MOVE;
                    nx_alu.smux = 1'b1;
                    nx_alu.imm  = load_data;
                    nx_alu.we   = expand_zz(op_zz_q);
                    fetched     = 2'd1;        // second opcode byte
                    nx_phase    = FETCH;
                end
                ST_RAM: if (mem_done) begin
                    nx_stram_en = 1'b0;
                    fetched     = 2'd1;
                    nx_phase    = FETCH;
                end
                EXEC: begin
                    nx_phase = FETCH;
                    casez (op[7:0])
                        8'b1000_1???: begin    // LD R,r
                            nx_alu.src = alu.dst;
                            nx_alu.dst = expand_reg(op[2:0], op_zz_q);
                            nx_alu.op  = ALU_MOVE;
                            nx_alu.we  = expand_zz(op_zz_q);
                            fetched    = 2'd1;
                        end
                        8'b1001_1???: begin    // LD r,R
                            nx_alu.src = expand_reg(op[2:0], op_zz_q);
                            nx_alu.op  = ALU_MOVE;
                            nx_alu.we  = expand_zz(op_zz_q);
                            fetched    = 2'd1;
                        end
                        default: nx_phase = ILLEGAL;
                    endcase
                end
                FILL_IMM: begin
                    nx_phase  = FETCH;
                    nx_alu.we = expand_zz(op_zz_q);
                    if (op_zz_q == 2'd1) begin
                        nx_alu.imm[31:16] = '0;
                        nx_alu.imm[15:8]  = op[7:0];
                        fetched           = 2'd1;
                    end else begin
                        nx_alu.imm[31:8] = op[23:0];
                        fetched          = 2'd3;
                    end
                end
                ILLEGAL: ;                     // sticky
                default: nx_phase = ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            phase_q  <= FETCH;
            alu      <= '0;
            op_zz_q  <= '0;
            idx_en   <= 1'b0;
            ldram_en <= 1'b0;
            stram_en <= 1'b0;
            ram_wait <= 1'b0;
        end else begin
            phase_q  <= nx_phase;
            alu      <= nx_alu;
            op_zz_q  <= nx_op_zz;
            idx_en   <= nx_idx_en;
            ldram_en <= nx_ldram_en;
            stram_en <= nx_stram_en;
            ram_wait <= fetched != 2'd0; // new window and register write settle
        end
    end

    assign illegal = (phase_q == ILLEGAL);

    assert property (@(posedge clk) disable iff (rst) !(ldram_en && stram_en));

endmodule

// ==== source/reg_bank.sv ====
// reg_bank
// Four current-bank long registers (XWA, XBC, XDE, XHL) with byte lane
// writes. Presents the source operand aligned to bit 0 and performs the
// move data path into the destination lane.
`timescale 1ns/1ps

module reg_bank import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  alu_ctrl_t alu,
    output long_t     src_val
);

    long_t      regs_q [4];
    logic [1:0] src_sel, src_lane;
    logic [1:0] dst_sel, dst_lane;
    long_t      wr_val;
    long_t      wr_data;
    logic [3:0] lane_we;

    // bank nibble ignored, only one bank exists
    assign src_sel  = alu.src[3:2];
    assign src_lane = alu.src[1:0];
    assign dst_sel  = alu.dst[3:2];
    assign dst_lane = alu.dst[1:0];

    assign src_val = regs_q[src_sel] >> {src_lane, 3'b000};
    assign wr_val  = alu.smux ? alu.imm : src_val;
    assign wr_data = wr_val << {dst_lane, 3'b000};

    always_comb begin
        case (alu.we)
            3'b001:  lane_we = 4'b0001 << dst_lane;
            3'b010:  lane_we = 4'b0011 << dst_lane;
            3'b100:  lane_we = 4'b1111;
            default: lane_we = 4'b0000;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int r = 0; r < 4; r++) begin
                regs_q[r] <= '0;
            end
        end else if (alu.op == ALU_MOVE) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_we[b]) regs_q[dst_sel][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

endmodule

// ==== source/idx_unit.sv ====
// idx_unit
// Indexed addressing and data-memory access. Forms base + signed 8-bit
// displacement from the prefix bytes, then runs one four-phase load or
// store and reports completion with a single-cycle mem_done.
`timescale 1ns/1ps

module idx_unit import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       idx_en,
    input  long_t      op,
    output logic       idx_ok,
    output fetch_cnt_t idx_fetched,
    input  long_t      base_val,
    input  logic       ldram_en,
    input  logic       stram_en,
    input  long_t      src_val,
    output logic       dmem_req,
    output mem_cmd_t   dmem_cmd,
    input  logic       dmem_ack,
    input  long_t      dmem_rdata,
    output long_t      load_data,
    output logic       mem_done
);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_REQ, S_DROP} mem_state_e;

    mem_state_e state_q;
    long_t      addr_q;
    zz_t        prefix_zz_q;
    long_t      disp;
    logic       start_idx, start_mem, got_ack;

    assign disp        = {{24{op[15]}}, op[15:8]};
    assign start_idx   = (state_q == S_IDLE) && idx_en;
    assign start_mem   = (state_q == S_ADDR) && (ldram_en || stram_en);
    assign got_ack     = (state_q == S_REQ) && dmem_ack;
    assign idx_ok      = (state_q == S_ADDR);
    assign idx_fetched = start_idx ? 2'd2 : 2'd0; // prefix and displacement

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q  <= S_IDLE;
            dmem_req <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state_q)
                S_IDLE: if (start_idx) state_q <= S_ADDR;
                S_ADDR: begin
                    if (start_mem) begin
                        dmem_req <= 1'b1;
                        state_q  <= S_REQ;
                    end else if (!idx_en) begin
                        state_q  <= S_IDLE;  // decode gave up
                    end
                end
                S_REQ: if (dmem_ack) begin
                    dmem_req <= 1'b0;
                    state_q  <= S_DROP;
                end
                S_DROP: if (!dmem_ack) begin
                    mem_done <= 1'b1;
                    state_q  <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_idx) begin
            addr_q      <= base_val + disp;
            prefix_zz_q <= op[5:4];
        end
        if (start_mem) begin
            dmem_cmd.addr <= addr_q;
            dmem_cmd.data <= src_val;
            dmem_cmd.zz   <= stram_en ? op[5:4] : prefix_zz_q; // store size in 2nd byte
            dmem_cmd.wr   <= stram_en;
        end
        if (got_ack && !dmem_cmd.wr) load_data <= dmem_rdata;
    end

    assert property (@(posedge clk) disable iff (rst)
        dmem_req && $past(dmem_req) |-> $stable(dmem_cmd));

endmodule

// ==== source/cpu_top.sv ====
// cpu_top
// tlcs_lite core top level. Connects the fetch buffer, control FSM,
// register bank and index unit, and exposes both memory ports and the
// illegal-opcode flag.
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int BUF_BYTES = 8
) (
    input  logic     clk,
    input  logic     rst,
    output logic     imem_req,
    output long_t    imem_addr,
    input  logic     imem_ack,
    input  byte_t    imem_data,
    output logic     dmem_req,
    output mem_cmd_t dmem_cmd,
    input  logic     dmem_ack,
    input  long_t    dmem_rdata,
    output logic     illegal
);

    long_t      op;
    logic       op_ok;
    fetch_cnt_t fetched, idx_fetched;
    logic       idx_en, idx_ok;
    logic       ldram_en, stram_en, mem_done;
    long_t      load_data;
    alu_ctrl_t  alu;
    long_t      src_val;   // base register during IDX, store data after

    op_fetch #(.BUF_BYTES(BUF_BYTES)) fetch_i (
        .clk, .rst, .imem_req, .imem_addr, .imem_ack, .imem_data,
        .fetched, .idx_fetched, .op, .op_ok
    );

    ctrl ctrl_i (
        .clk, .rst, .op, .op_ok, .fetched, .idx_en, .idx_ok,
        .ldram_en, .stram_en, .mem_done, .load_data, .alu, .illegal
    );

    reg_bank regs_i (
        .clk, .rst, .alu, .src_val
    );

    idx_unit idx_i (
        .clk, .rst, .idx_en, .op, .idx_ok, .idx_fetched,
        .base_val   (src_val),
        .ldram_en, .stram_en, .src_val,
        .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata, .load_data, .mem_done
    );

endmodule

// ==== bench/cpu_tb.sv ====
// cpu_tb
// Testbench for the tlcs_lite core. Loads program, data memory and the
// expected store records from a hex file, answers both four-phase ports
// with LFSR-driven ack delays and checks every store as it happens.
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*;;

    logic     clk;
    logic     rst;
    logic     imem_req;
    long_t    imem_addr;
    logic     imem_ack;
    byte_t    imem_data;
    logic     dmem_req;
    mem_cmd_t dmem_cmd;
    logic     dmem_ack;
    long_t    dmem_rdata;
    logic     illegal;

    byte_t       image [0:767];   // 000 program, 100 data, 200 records
    byte_t       dmem [0:255];
    logic [31:0] lfsr_state;
    logic [31:0] exp_fetch_addr;  // fetch runs sequentially from 0
    int          rec_idx;
    int          n_records;
    int          prog_len;
    int          imem_cnt, dmem_cnt;
    logic        imem_armed, dmem_armed;
    logic        illegal_seen;

    cpu_top #(.BUF_BYTES(8)) dut_i (
        .clk, .rst, .imem_req, .imem_addr, .imem_ack, .imem_data,
        .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata, .illegal
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        d = int'(bits);                  // 0 to 3 cycles
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // compare one store with the next record, then apply it and read the word back
    task automatic apply_store(input mem_cmd_t cmd);
        int          base;
        int          nbytes;
        int          wr_bytes;
        logic [31:0] exp_word, readback;
        if (rec_idx >= n_records) abort_run("store seen after the last expected record");
        base   = 16'h200 + 6 * rec_idx;
        nbytes = (image[base+1] == 8'd0) ? 1 : (image[base+1] == 8'd1) ? 2 : 4;
        check_value("store address", cmd.addr, {24'd0, image[base]});
        check_value("store size", {30'd0, cmd.zz}, {24'd0, image[base+1]});
        for (int i = 0; i < 4; i++) begin  // record bytes over the old contents
            exp_word[8*i +: 8] = (i < nbytes) ? image[base+2+i] : dmem[8'(cmd.addr + i)];
        end
        wr_bytes = (cmd.zz == 2'd0) ? 1 : (cmd.zz == 2'd1) ? 2 : 4;
        for (int i = 0; i < wr_bytes; i++) begin
            dmem[8'(cmd.addr + i)] = cmd.data[8*i +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            readback[8*i +: 8] = dmem[8'(cmd.addr + i)];
        end
        check_value("memory readback", readback, exp_word);
        rec_idx++;
    endtask

    // both memory models in one process so the LFSR draw order is fixed
    always @(negedge clk) begin
        if (!rst) begin
            if (imem_ack) begin
                if (!imem_req) imem_ack = 1'b0;
            end else if (imem_req) begin
                if (!imem_armed) begin
                    draw_delay(imem_cnt);
                    imem_armed = 1'b1;
                end
                if (imem_cnt == 0) begin
                    check_value("fetch address", imem_addr, exp_fetch_addr);
                    exp_fetch_addr = exp_fetch_addr + 32'd1;
                    imem_data  = (imem_addr < 256) ? image[imem_addr[7:0]] : 8'h00;
                    imem_ack   = 1'b1;
                    imem_armed = 1'b0;
                end else begin
                    imem_cnt--;
                end
            end
            if (dmem_ack) begin
                if (!dmem_req) dmem_ack = 1'b0;
            end else if (dmem_req) begin
                if (!dmem_armed) begin
                    draw_delay(dmem_cnt);
                    dmem_armed = 1'b1;
                end
                if (dmem_cnt == 0) begin
                    if (dmem_cmd.wr) begin
                        apply_store(dmem_cmd);
                    end else begin
                        for (int i = 0; i < 4; i++) begin
                            dmem_rdata[8*i +: 8] = dmem[8'(dmem_cmd.addr + i)];
                        end
                    end
                    dmem_ack   = 1'b1;
                    dmem_armed = 1'b0;
                end else begin
                    dmem_cnt--;
                end
            end
            // illegal may only rise once every store has been seen
            if (illegal) begin
                if (rec_idx < n_records) abort_run("illegal raised before all stores");
                illegal_seen = 1'b1;
            end
        end
    end

    initial begin
        int cycles;
        rst            = 1'b1;
        imem_ack       = 1'b0;
        imem_data      = '0;
        dmem_ack       = 1'b0;
        dmem_rdata     = '0;
        lfsr_state     = 32'h5a58_dba9;
        exp_fetch_addr = '0;
        imem_armed     = 1'b0;
        dmem_armed     = 1'b0;
        illegal_seen   = 1'b0;
        imem_cnt       = 0;
        dmem_cnt       = 0;
        rec_idx        = 0;
        for (int i = 0; i < 768; i++) begin
            image[i] = (i >= 256 && i < 512) ? (8'(i) ^ 8'h96) : 8'h00; // data fill
        end
        $readmemh("bench/prog_input.hex", image);
        for (int a = 0; a < 256; a++) begin
            dmem[a] = image[256 + a];
        end
        n_records = 0;
        while (n_records < 40 && image[16'h200 + 6 * n_records + 1] != 8'hff) begin
            n_records++;
        end
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            if (image[i] != 8'h00) prog_len = i + 1;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!(rec_idx == n_records && illegal_seen)) begin
            @(posedge clk);
            cycles++;
            if (cycles >= 40 * prog_len) abort_run("timeout waiting for stores and illegal");
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tlcs_lite.f ====
source/cpu_pkg.sv
source/op_fetch.sv
source/ctrl.sv
source/reg_bank.sv
source/idx_unit.sv
source/cpu_top.sv
bench/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the tlcs_lite core

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= tlcs_lite.f
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf obj_dir

// ==== bench/prog_input.hex ====
// @000 program bytes, @100 initial data memory bytes (offset = data address)
// @200 store records of 6 bytes: addr, zz, data byte 0..3 (little-endian), zz FF ends
@000
43 80 00 00 00  // LD XHL,#00000080
40 44 33 22 11  // LD XWA,#11223344
20 AB           // LD W,#AB
31 78 56        // LD BC,#5678
23 9A           // LD C,#9A
E3 00 60        // LD (XHL+0),XWA
D3 04 51        // LD (XHL+4),BC
C3 FF 43        // LD (XHL-1),C
C3 08 40        // LD (XHL+8),W
E8 8A           // LD XDE,XWA
E3 10 62        // LD (XHL+10),XDE
42 0D F0 FE CA  // LD XDE,#CAFEF00D
E9 9A           // LD XBC,XDE  (r,R form)
E3 14 61        // LD (XHL+14),XBC
CD 88           // LD W,E
E3 18 60        // LD (XHL+18),XWA
E3 C0 21        // LD XBC,(XHL-40)
E3 30 61        // LD (XHL+30),XBC
D3 20 20        // LD WA,(XHL+20)
E3 34 60        // LD (XHL+34),XWA
C3 23 24        // LD D,(XHL+23)
D3 F0 52        // LD (XHL-10),DE
D3 21 52        // LD (XHL+21),DE  partial write over initialized word
00 00 FF        // NOPs then undefined opcode
@140
78 56 34 12
@1A0
EF BE AD DE
@200
80 02 44 AB 22 11
84 01 9A 56 00 00
7F 00 9A 00 00 00
88 00 AB 00 00 00
90 02 44 AB 22 11
94 02 0D F0 FE CA
98 02 44 0D 22 11
B0 02 78 56 34 12
B4 02 EF BE 22 11
70 01 0D DE 00 00
A1 01 0D DE 00 00
00 FF 00 00 00 00
